// File: design/mm_ram_pkg.sv
package mm_ram_pkg;

    // widths
    localparam int RAM_ADDR_WIDTH   = 16;
    localparam int ADDR_WIDTH       = 32;
    localparam int DATA_WIDTH       = 32;
    localparam int INSTR_DATA_WIDTH = 128;
    localparam int WORDS_PER_LINE   = 4;
    localparam int BE_WIDTH         = 4;

    // derived address widths of the word array
    localparam int BYTE_OFS_WIDTH  = $clog2(BE_WIDTH);
    localparam int LINE_OFS_WIDTH  = $clog2(WORDS_PER_LINE);
    localparam int WORD_ADDR_WIDTH = RAM_ADDR_WIDTH - BYTE_OFS_WIDTH;
    localparam int LINE_ADDR_WIDTH = WORD_ADDR_WIDTH - LINE_OFS_WIDTH;

    // memory-mapped control registers
    localparam logic [ADDR_WIDTH-1:0] TIMER_MASK_ADDR  = 32'h1500_0000;
    localparam logic [ADDR_WIDTH-1:0] TIMER_CNT_ADDR   = 32'h1500_0004;
    localparam logic [ADDR_WIDTH-1:0] TEST_STATUS_ADDR = 32'h2000_0000;
    localparam logic [ADDR_WIDTH-1:0] EXIT_ADDR        = 32'h2000_0004;

    localparam logic [DATA_WIDTH-1:0] TEST_PASS_CODE = 32'd123456789;
    localparam logic [DATA_WIDTH-1:0] TEST_FAIL_CODE = 32'd1;
    localparam int                    TIMER_IRQ_ID   = 3;

    typedef logic [INSTR_DATA_WIDTH-1:0] instr_data_t;
    typedef logic [DATA_WIDTH-1:0]       data_word_t;

    typedef struct packed {
        logic                  req;
        logic [ADDR_WIDTH-1:0] addr;
        logic                  we;
        logic [BE_WIDTH-1:0]   be;
        data_word_t            wdata;
    } data_req_t;

    // data port access as seen by the word array
    typedef struct packed {
        logic                       en;
        logic                       we;
        logic [BE_WIDTH-1:0]        be;
        logic [WORD_ADDR_WIDTH-1:0] addr;
        data_word_t                 wdata;
    } ram_wr_t;

    typedef struct packed {
        logic       mask_vld;
        logic       cnt_vld;
        logic       status_vld;
        logic       exit_vld;
        data_word_t wdata;
    } ctrl_wr_t;

    typedef enum logic [1:0] {
        SEL_RAM,
        SEL_ZERO,
        SEL_ERR
    } resp_sel_e;

endpackage

// File: design/mm_ram_decoder.sv
module mm_ram_decoder import mm_ram_pkg::*; (
    input  logic                       instr_req_i,
    input  logic [ADDR_WIDTH-1:0]      instr_addr_i,
    input  data_req_t                  data_req_i,
    output logic                       ram_instr_en_o,
    output logic [LINE_ADDR_WIDTH-1:0] ram_instr_addr_o,
    output ram_wr_t                    ram_data_o,
    output ctrl_wr_t                   ctrl_wr_o,
    output resp_sel_e                  instr_sel_o,
    output resp_sel_e                  data_sel_o
);

    logic instr_in_ram;
    logic data_in_ram;
    logic ctrl_hit;

    // ram covers the lowest 2**RAM_ADDR_WIDTH bytes
    assign instr_in_ram = (instr_addr_i[ADDR_WIDTH-1:RAM_ADDR_WIDTH] == '0);
    assign data_in_ram  = (data_req_i.addr[ADDR_WIDTH-1:RAM_ADDR_WIDTH] == '0);

    assign ctrl_hit = (data_req_i.addr == TIMER_MASK_ADDR)
                   || (data_req_i.addr == TIMER_CNT_ADDR)
                   || (data_req_i.addr == TEST_STATUS_ADDR)
                   || (data_req_i.addr == EXIT_ADDR);

    // the instruction line address drops the word and byte offsets
    assign ram_instr_en_o   = instr_req_i && instr_in_ram;
    assign ram_instr_addr_o = instr_addr_i[RAM_ADDR_WIDTH-1:BYTE_OFS_WIDTH+LINE_OFS_WIDTH];
    assign instr_sel_o      = instr_in_ram ? SEL_RAM : SEL_ERR;

    always_comb begin
        ram_data_o.en    = data_req_i.req && data_in_ram;
        ram_data_o.we    = data_req_i.we;
        ram_data_o.be    = data_req_i.be;
        ram_data_o.addr  = data_req_i.addr[RAM_ADDR_WIDTH-1:BYTE_OFS_WIDTH];
        ram_data_o.wdata = data_req_i.wdata;
    end

    // control registers are write only
    always_comb begin
        ctrl_wr_o.mask_vld   = 1'b0;
        ctrl_wr_o.cnt_vld    = 1'b0;
        ctrl_wr_o.status_vld = 1'b0;
        ctrl_wr_o.exit_vld   = 1'b0;
        ctrl_wr_o.wdata      = data_req_i.wdata;
        if (data_req_i.req && data_req_i.we) begin
            ctrl_wr_o.mask_vld   = (data_req_i.addr == TIMER_MASK_ADDR);
            ctrl_wr_o.cnt_vld    = (data_req_i.addr == TIMER_CNT_ADDR);
            ctrl_wr_o.status_vld = (data_req_i.addr == TEST_STATUS_ADDR);
            ctrl_wr_o.exit_vld   = (data_req_i.addr == EXIT_ADDR);
        end
    end

    always_comb begin
        if (data_req_i.we) begin
            data_sel_o = (data_in_ram || ctrl_hit) ? SEL_ZERO : SEL_ERR;
        end else begin
            data_sel_o = data_in_ram ? SEL_RAM : SEL_ERR;
        end
    end

endmodule

// File: design/mm_ram_dp_ram.sv
module mm_ram_dp_ram import mm_ram_pkg::*; (
    input  logic                       clk_i,
    input  logic                       instr_en_i,
    input  logic [LINE_ADDR_WIDTH-1:0] instr_addr_i,
    input  ram_wr_t                    data_i,
    output instr_data_t                instr_rdata_o,
    output data_word_t                 data_rdata_o
);

    localparam int NUM_WORDS = 2 ** WORD_ADDR_WIDTH;

    data_word_t mem [NUM_WORDS];

    // lowest word of a line goes to the lowest bits
    always_ff @(posedge clk_i) begin
        if (instr_en_i) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                instr_rdata_o[w*DATA_WIDTH +: DATA_WIDTH] <=
                    mem[{instr_addr_i, LINE_OFS_WIDTH'(w)}];
            end
        end
    end

    // data port with byte enables
    always_ff @(posedge clk_i) begin
        if (data_i.en) begin
            if (data_i.we) begin
                for (int b = 0; b < BE_WIDTH; b++) begin
                    if (data_i.be[b]) begin
                        mem[data_i.addr][b*8 +: 8] <= data_i.wdata[b*8 +: 8];
                    end
                end
            end
            // read returns the word as it was before this edge
            data_rdata_o <= mem[data_i.addr];
        end
    end

endmodule

// File: design/mm_ram_ctrl_regs.sv
module mm_ram_ctrl_regs import mm_ram_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  ctrl_wr_t   ctrl_wr_i,
    input  logic       irq_ack_i,
    input  logic [4:0] irq_id_i,
    output logic       irq_o,
    output logic       tests_passed_o,
    output logic       tests_failed_o,
    output logic       exit_valid_o,
    output data_word_t exit_value_o
);

    // only the timer bit of the mask has a meaning here
    logic       timer_en_q;
    data_word_t timer_cnt_q;
    logic       irq_q;
    logic       passed_q;
    logic       failed_q;
    logic       exit_valid_q;
    data_word_t exit_value_q;
    logic       timer_ack;

    assign timer_ack = irq_ack_i && (irq_id_i == 5'(TIMER_IRQ_ID));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            timer_en_q  <= 1'b0;
            timer_cnt_q <= '0;
            irq_q       <= 1'b0;
        end else begin
            if (ctrl_wr_i.mask_vld) begin
                timer_en_q <= ctrl_wr_i.wdata[TIMER_IRQ_ID];
            end

            if (ctrl_wr_i.cnt_vld) begin
                timer_cnt_q <= ctrl_wr_i.wdata;
            end else if (timer_cnt_q != '0) begin
                timer_cnt_q <= timer_cnt_q - 1'b1;
            end

            // interrupt fires on the 1 to 0 step of the count
            if (!ctrl_wr_i.cnt_vld && timer_cnt_q == data_word_t'(1) && timer_en_q) begin
                irq_q <= 1'b1;
            end
            // acknowledge wins over a new timeout
            if (timer_ack) begin
                irq_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            passed_q     <= 1'b0;
            failed_q     <= 1'b0;
            exit_valid_q <= 1'b0;
            exit_value_q <= '0;
        end else begin
            passed_q     <= ctrl_wr_i.status_vld && (ctrl_wr_i.wdata == TEST_PASS_CODE);
            failed_q     <= ctrl_wr_i.status_vld && (ctrl_wr_i.wdata == TEST_FAIL_CODE);
            exit_valid_q <= ctrl_wr_i.exit_vld;
            if (ctrl_wr_i.exit_vld) begin
                exit_value_q <= ctrl_wr_i.wdata;
            end
        end
    end

    assign irq_o          = irq_q;
    assign tests_passed_o = passed_q;
    assign tests_failed_o = failed_q;
    assign exit_valid_o   = exit_valid_q;
    assign exit_value_o   = exit_value_q;

endmodule

// File: design/mm_ram_resp_stage.sv
module mm_ram_resp_stage import mm_ram_pkg::*; #(
    parameter type payload_t = data_word_t
) (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      req_i,
    input  resp_sel_e sel_i,
    input  payload_t  mem_rdata_i,
    output logic      rvalid_o,
    output payload_t  rdata_o,
    output logic      err_o
);

    logic      valid_q;
    resp_sel_e sel_q;

    // idle cycles fall back to the zero select so nothing leaks out
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
            sel_q   <= SEL_ZERO;
        end else begin
            valid_q <= req_i;
            sel_q   <= req_i ? sel_i : SEL_ZERO;
        end
    end

    assign rvalid_o = valid_q;
    assign rdata_o  = (sel_q == SEL_RAM) ? mem_rdata_i : '0;
    assign err_o    = (sel_q == SEL_ERR);

endmodule

// File: design/mm_ram.sv
module mm_ram import mm_ram_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,

    input  logic                  instr_req_i,
    input  logic [ADDR_WIDTH-1:0] instr_addr_i,
    output logic                  instr_gnt_o,
    output logic                  instr_rvalid_o,
    output logic                  instr_err_o,
    output instr_data_t           instr_rdata_o,

    input  data_req_t             data_req_i,
    output logic                  data_gnt_o,
    output logic                  data_rvalid_o,
    output logic                  data_err_o,
    output data_word_t            data_rdata_o,

    input  logic                  irq_ack_i,
    input  logic [4:0]            irq_id_i,
    output logic                  irq_o,

    output logic                  tests_passed_o,
    output logic                  tests_failed_o,
    output logic                  exit_valid_o,
    output data_word_t            exit_value_o
);

    logic                       ram_instr_en;
    logic [LINE_ADDR_WIDTH-1:0] ram_instr_addr;
    ram_wr_t                    ram_data;
    ctrl_wr_t                   ctrl_wr;
    resp_sel_e                  instr_sel;
    resp_sel_e                  data_sel;
    instr_data_t                ram_instr_rdata;
    data_word_t                 ram_data_rdata;

    // every target accepts in the same cycle
    assign instr_gnt_o = instr_req_i;
    assign data_gnt_o  = data_req_i.req;

    mm_ram_decoder i_decoder (
        .instr_req_i      (instr_req_i),
        .instr_addr_i     (instr_addr_i),
        .data_req_i       (data_req_i),
        .ram_instr_en_o   (ram_instr_en),
        .ram_instr_addr_o (ram_instr_addr),
        .ram_data_o       (ram_data),
        .ctrl_wr_o        (ctrl_wr),
        .instr_sel_o      (instr_sel),
        .data_sel_o       (data_sel)
    );

    mm_ram_dp_ram i_dp_ram (
        .clk_i         (clk_i),
        .instr_en_i    (ram_instr_en),
        .instr_addr_i  (ram_instr_addr),
        .data_i        (ram_data),
        .instr_rdata_o (ram_instr_rdata),
        .data_rdata_o  (ram_data_rdata)
    );

    mm_ram_ctrl_regs i_ctrl_regs (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .ctrl_wr_i      (ctrl_wr),
        .irq_ack_i      (irq_ack_i),
        .irq_id_i       (irq_id_i),
        .irq_o          (irq_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o)
    );

    mm_ram_resp_stage #(.payload_t(instr_data_t)) i_instr_resp (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_i       (instr_req_i),
        .sel_i       (instr_sel),
        .mem_rdata_i (ram_instr_rdata),
        .rvalid_o    (instr_rvalid_o),
        .rdata_o     (instr_rdata_o),
        .err_o       (instr_err_o)
    );

    mm_ram_resp_stage #(.payload_t(data_word_t)) i_data_resp (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_i       (data_req_i.req),
        .sel_i       (data_sel),
        .mem_rdata_i (ram_data_rdata),
        .rvalid_o    (data_rvalid_o),
        .rdata_o     (data_rdata_o),
        .err_o       (data_err_o)
    );

endmodule

// File: testbench/mm_ram_assert.sv
module mm_ram_assert import mm_ram_pkg::*; (
    input logic        clk_i,
    input logic        rst_ni,
    input logic        instr_req_i,
    input logic        instr_gnt_o,
    input logic        instr_rvalid_o,
    input logic        instr_err_o,
    input instr_data_t instr_rdata_o,
    input data_req_t   data_req_i,
    input logic        data_gnt_o,
    input logic        data_rvalid_o,
    input logic        data_err_o,
    input data_word_t  data_rdata_o,
    input logic        irq_ack_i,
    input logic [4:0]  irq_id_i,
    input logic        irq_o
);

    grant_equals_request: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (instr_gnt_o == instr_req_i) && (data_gnt_o == data_req_i.req))
        else $error("grant differs from request");

    // no back-pressure, so read-valid is the request delayed by one cycle
    rvalid_after_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (instr_rvalid_o == $past(instr_req_i)) && (data_rvalid_o == $past(data_req_i.req)))
        else $error("read-valid does not follow the granted request by one cycle");

    zero_data_on_error: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (!instr_err_o || instr_rdata_o == '0) && (!data_err_o || data_rdata_o == '0))
        else $error("read data not zero with error set");

    irq_low_after_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (irq_ack_i && irq_id_i == 5'(TIMER_IRQ_ID)) |=> !irq_o)
        else $error("timer interrupt still high after acknowledge");

endmodule

bind mm_ram mm_ram_assert i_mm_ram_assert (.*);

// File: testbench/tb_mm_ram.sv
module tb_mm_ram import mm_ram_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 4000;

    logic clk;
    logic rst_n;
    logic instr_req;
    logic [31:0] instr_addr;
    data_req_t data_req;
    logic irq_ack;
    logic [4:0] irq_id;
    logic instr_gnt;
    logic instr_rvalid;
    logic instr_err;
    instr_data_t instr_rdata;
    logic data_gnt;
    logic data_rvalid;
    logic data_err;
    data_word_t data_rdata;
    logic irq;
    logic passed;
    logic failed;
    logic exit_valid;
    data_word_t exit_value;

    // reference RAM keyed by word address
    data_word_t ram_model [int unsigned];
    data_word_t exp_data_q[$];
    logic exp_derr_q[$];
    instr_data_t exp_instr_q[$];
    logic exp_ierr_q[$];
    int checks = 0;
    int errors = 0;
    int err_mark = 0;
    int cycles = 0;
    int pass_pulses = 0;
    int fail_pulses = 0;
    int exit_pulses = 0;
    data_word_t exit_seen = '0;

    mm_ram UUT (
        .clk_i(clk), .rst_ni(rst_n),
        .instr_req_i(instr_req), .instr_addr_i(instr_addr), .instr_gnt_o(instr_gnt),
        .instr_rvalid_o(instr_rvalid), .instr_err_o(instr_err), .instr_rdata_o(instr_rdata),
        .data_req_i(data_req), .data_gnt_o(data_gnt), .data_rvalid_o(data_rvalid),
        .data_err_o(data_err), .data_rdata_o(data_rdata),
        .irq_ack_i(irq_ack), .irq_id_i(irq_id), .irq_o(irq),
        .tests_passed_o(passed), .tests_failed_o(failed),
        .exit_valid_o(exit_valid), .exit_value_o(exit_value)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, responses still pending", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    // enabled bytes take the new data and the rest keep the old word
    function automatic data_word_t merge_be(data_word_t old_w, data_word_t new_w,
                                            logic [3:0] be);
        data_word_t res;
        for (int b = 0; b < 4; b++) begin
            res[b*8 +: 8] = be[b] ? new_w[b*8 +: 8] : old_w[b*8 +: 8];
        end
        return res;
    endfunction

    task automatic check(input string name, input logic [127:0] got,
                         input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    // responses and status pulses are sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (data_rvalid && exp_data_q.size() == 0) begin
                errors++;
                $display("data response arrived without a pending request");
            end else if (data_rvalid) begin
                check("data_rdata_o", data_rdata, exp_data_q.pop_front());
                check("data_err_o", data_err, exp_derr_q.pop_front());
            end
            if (instr_rvalid && exp_instr_q.size() == 0) begin
                errors++;
                $display("instruction response arrived without a pending fetch");
            end else if (instr_rvalid) begin
                check("instr_rdata_o", instr_rdata, exp_instr_q.pop_front());
                check("instr_err_o", instr_err, exp_ierr_q.pop_front());
            end
            pass_pulses += passed;
            fail_pulses += failed;
            if (exit_valid) begin
                exit_pulses++;
                exit_seen = exit_value;
            end
        end
    end

    task automatic data_access(input logic we, input logic [31:0] addr, input logic [3:0] be,
                               input data_word_t wdata, input logic exp_err);
        int unsigned w;
        w = addr[RAM_ADDR_WIDTH-1:2];
        @(posedge clk);
        data_req <= '{req: 1'b1, addr: addr, we: we, be: be, wdata: wdata};
        instr_req <= 1'b0;
        exp_derr_q.push_back(exp_err);
        if (exp_err || we) begin
            exp_data_q.push_back('0);
        end else begin
            exp_data_q.push_back(ram_model[w]);
        end
        if (we && addr[31:RAM_ADDR_WIDTH] == '0) begin
            ram_model[w] = merge_be(ram_model.exists(w) ? ram_model[w] : '0, wdata, be);
        end
    endtask

    task automatic fetch(input logic [31:0] addr, input logic exp_err);
        instr_data_t line;
        int unsigned w0;
        line = '0;
        w0 = {addr[RAM_ADDR_WIDTH-1:4], 2'b00};
        for (int i = 0; i < 4 && !exp_err; i++) begin
            line[i*32 +: 32] = ram_model[w0 + i];
        end
        @(posedge clk);
        instr_req <= 1'b1;
        instr_addr <= addr;
        data_req.req <= 1'b0;
        exp_instr_q.push_back(line);
        exp_ierr_q.push_back(exp_err);
    endtask

    task automatic finish_test(input string name);
        @(posedge clk);
        data_req.req <= 1'b0;
        instr_req <= 1'b0;
        while (exp_data_q.size() != 0 || exp_instr_q.size() != 0) begin
            @(posedge clk);
        end
        $display("test %s: %0d mismatches", name, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        logic [31:0] addrs [16];
        logic [31:0] line_addr;
        data_word_t exit_val;
        int n;
        int edges;
        logic seen;
        void'($urandom(32'h19fa_0d82));
        rst_n = 1'b0;
        instr_req = 1'b0;
        instr_addr = '0;
        data_req = '0;
        irq_ack = 1'b0;
        irq_id = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // full word first so partial writes never leave unknown bytes
        foreach (addrs[i]) begin
            addrs[i] = {16'h0, 16'($urandom) & 16'hfffc};
            data_access(1'b1, addrs[i], 4'hf, $urandom, 1'b0);
            data_access(1'b1, addrs[i], 4'($urandom), $urandom, 1'b0);
        end
        foreach (addrs[i]) data_access(1'b0, addrs[i], 4'hf, '0, 1'b0);
        finish_test("byte-enable writes and reads");

        for (int l = 0; l < 4; l++) begin
            line_addr = {16'h0, 16'($urandom) & 16'hfff0};
            for (int i = 0; i < 4; i++) data_access(1'b1, line_addr + 4*i, 4'hf, $urandom, 1'b0);
            fetch(line_addr, 1'b0);
        end
        finish_test("instruction line fetch");

        data_access(1'b0, 32'h0001_0000 | (32'($urandom) & 32'h0000_fffc), 4'hf, '0, 1'b1);
        data_access(1'b1, 32'h3000_0000, 4'hf, $urandom, 1'b1);
        data_access(1'b1, TIMER_MASK_ADDR, 4'hf, '0, 1'b0);
        fetch(32'h0002_0000, 1'b1);
        finish_test("unmapped accesses");

        n = 5 + $urandom_range(15);
        data_access(1'b1, TIMER_MASK_ADDR, 4'hf, 32'h8, 1'b0);
        data_access(1'b1, TIMER_CNT_ADDR, 4'hf, n, 1'b0);
        // this edge loads the count
        @(posedge clk);
        data_req.req <= 1'b0;
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end while (!irq && edges < 64);
        check("irq_o edges to rise", edges, n);
        @(posedge clk);
        irq_ack <= 1'b1;
        irq_id <= 5'd3;
        @(posedge clk);
        irq_ack <= 1'b0;
        @(negedge clk);
        check("irq_o", irq, 1'b0);
        data_access(1'b1, TIMER_MASK_ADDR, 4'hf, '0, 1'b0);
        data_access(1'b1, TIMER_CNT_ADDR, 4'hf, n, 1'b0);
        finish_test("timer setup");
        seen = 1'b0;
        repeat (n + 4) begin
            @(negedge clk);
            seen |= irq;
        end
        check("irq_o masked", seen, 1'b0);
        finish_test("timer interrupt");

        exit_val = $urandom;
        data_access(1'b1, TEST_STATUS_ADDR, 4'hf, 32'd123456789, 1'b0);
        data_access(1'b1, TEST_STATUS_ADDR, 4'hf, 32'd1, 1'b0);
        data_access(1'b1, TEST_STATUS_ADDR, 4'hf, 32'd7, 1'b0);
        data_access(1'b1, EXIT_ADDR, 4'hf, exit_val, 1'b0);
        finish_test("status writes");
        check("tests_passed_o pulses", pass_pulses, 1);
        check("tests_failed_o pulses", fail_pulses, 1);
        check("exit_valid_o pulses", exit_pulses, 1);
        check("exit_value_o", exit_seen, exit_val);
        finish_test("status and exit");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: mm_ram.f
design/mm_ram_pkg.sv
design/mm_ram_decoder.sv
design/mm_ram_dp_ram.sv
design/mm_ram_ctrl_regs.sv
design/mm_ram_resp_stage.sv
design/mm_ram.sv
testbench/mm_ram_assert.sv
testbench/tb_mm_ram.sv

// File: Bender.yml
package:
  name: mm_ram

sources:
  - files:
      - design/mm_ram_pkg.sv
      - design/mm_ram_decoder.sv
      - design/mm_ram_dp_ram.sv
      - design/mm_ram_ctrl_regs.sv
      - design/mm_ram_resp_stage.sv
      - design/mm_ram.sv
  - target: test
    files:
      - testbench/mm_ram_assert.sv
      - testbench/tb_mm_ram.sv
